// File: rtl/vdp_cmd_settings.svh
// Width and limit macros for the drawing-command engine
`ifndef VDP_CMD_SETTINGS_SVH
`define VDP_CMD_SETTINGS_SVH

// Destination x
// Bit 8 set means past the right edge
`define VDP_CMD_X_W 9

// Destination y
`define VDP_CMD_Y_W 10

// NX and NY counts
`define VDP_CMD_N_W 10

// Byte address into VRAM
`define VDP_CMD_ADDR_W 17

// CPU register index
// Index 0 is R32
`define VDP_CMD_REGNUM_W 4

`endif

// File: rtl/vdp_cmd_reg_pkg.sv
// Command opcodes, logic operations and the register snapshot struct
`include "vdp_cmd_settings.svh"

package vdp_cmd_reg_pkg;

  // Upper nibble of R46
  // Codes not listed behave as STOP
  typedef enum logic [3:0] {
    OP_STOP  = 4'b0000,
    OP_POINT = 4'b0100,
    OP_PSET  = 4'b0101,
    OP_LMMV  = 4'b1000,
    OP_HMMV  = 4'b1100
  } cmd_op_t;

  // Lower nibble of R46
  // Bit 3 is the transparent flag
  typedef enum logic [3:0] {
    LOG_IMP  = 4'h0,
    LOG_AND  = 4'h1,
    LOG_OR   = 4'h2,
    LOG_XOR  = 4'h3,
    LOG_NOT  = 4'h4,
    LOG_TIMP = 4'h8,
    LOG_TAND = 4'h9,
    LOG_TOR  = 4'hA,
    LOG_TXOR = 4'hB,
    LOG_TNOT = 4'hC
  } logop_t;

  // Registers frozen when R46 is written
  typedef struct packed {
    logic [`VDP_CMD_X_W-1:0] dx;
    logic [`VDP_CMD_Y_W-1:0] dy;
    logic [`VDP_CMD_N_W-1:0] nx;
    logic [`VDP_CMD_N_W-1:0] ny;
    logic [7:0]              clr;
    logic                    dix;
    logic                    diy;
    cmd_op_t                 op;
    logop_t                  logop;
  } cmd_regs_t;

endpackage

// File: rtl/vdp_cmd_pix_pkg.sv
// Screen mode, VRAM address type and pixel request struct
`include "vdp_cmd_settings.svh"

package vdp_cmd_pix_pkg;

  // Pixel format of the bitmap
  // Commands are ignored in OFF
  typedef enum logic [1:0] {
    SCR_OFF = 2'b00,
    SCR_G4  = 2'b01,
    SCR_G7  = 2'b10
  } scr_mode_t;

  typedef logic [`VDP_CMD_ADDR_W-1:0] vram_addr_t;

  // What the memory stage does with one pixel
  typedef enum logic [1:0] {
    KIND_FILL_BYTE = 2'b00,
    KIND_MERGE     = 2'b01,
    KIND_PROBE     = 2'b10
  } pix_kind_t;

  // One pixel job from walker to VRAM port
  typedef struct packed {
    logic [`VDP_CMD_X_W-1:0] x;
    logic [`VDP_CMD_Y_W-1:0] y;
    logic [7:0]              colour;
    vdp_cmd_reg_pkg::logop_t logop;
    pix_kind_t               kind;
  } pix_req_t;

endpackage

// File: rtl/vdp_cmd_regs.sv
// Command register file with CPU write handshake, launch, abort, CLR and CE
`include "vdp_cmd_settings.svh"

module vdp_cmd_regs (
  input  logic                           clk21m,
  input  logic                           reset,
  input  logic                           reg_wr_req,
  input  logic [`VDP_CMD_REGNUM_W-1:0]   reg_num,
  input  logic [7:0]                     reg_data,
  input  vdp_cmd_pix_pkg::scr_mode_t     scr_mode,
  input  logic                           busy,
  input  logic                           point_load,
  input  logic [7:0]                     probe_data,
  output logic                           reg_wr_ack,
  output vdp_cmd_reg_pkg::cmd_regs_t     cmd,
  output logic                           launch,
  output logic                           abort,
  output logic [7:0]                     clr,
  output logic                           ce
);

  // R36 to R43 and R45
  // R32 to R35 are acknowledged but not stored
  logic [`VDP_CMD_X_W-1:0] dx;
  logic [`VDP_CMD_Y_W-1:0] dy;
  logic [`VDP_CMD_N_W-1:0] nx;
  logic [`VDP_CMD_N_W-1:0] ny;
  logic                    dix;
  logic                    diy;

  logic                       wr_pend;
  logic                       cmr_wr;
  vdp_cmd_reg_pkg::cmd_op_t   new_op;
  logic [7:0]                 clr_mask;

  assign wr_pend = reg_wr_req != reg_wr_ack;
  assign cmr_wr  = wr_pend && (reg_num == 4'd14);

  // Unknown opcodes fold to STOP
  always_comb begin
    case (vdp_cmd_reg_pkg::cmd_op_t'(reg_data[7:4]))
      vdp_cmd_reg_pkg::OP_POINT,
      vdp_cmd_reg_pkg::OP_PSET,
      vdp_cmd_reg_pkg::OP_LMMV,
      vdp_cmd_reg_pkg::OP_HMMV: new_op = vdp_cmd_reg_pkg::cmd_op_t'(reg_data[7:4]);
      default:                  new_op = vdp_cmd_reg_pkg::OP_STOP;
    endcase
  end

  // Pixel width of CLR
  // HMMV works on whole bytes
  assign clr_mask = (scr_mode == vdp_cmd_pix_pkg::SCR_G4 &&
                     cmd.op != vdp_cmd_reg_pkg::OP_HMMV) ? 8'h0F : 8'hFF;

  always_ff @(posedge clk21m or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      launch     <= 1'b0;
      abort      <= 1'b0;
      clr        <= 8'h00;
      ce         <= 1'b0;
    end else begin
      launch <= 1'b0;
      abort  <= 1'b0;
      // Set by launch and held while the walker runs
      ce     <= launch | (ce & busy);
      // POINT result
      if (point_load) begin
        clr <= probe_data;
      end
      if (wr_pend) begin
        reg_wr_ack <= ~reg_wr_ack;
        if (reg_num == 4'd12) begin
          clr <= ce ? (reg_data & clr_mask) : reg_data;
        end
        // Any R46 write kills the running command
        if (cmr_wr) begin
          abort  <= 1'b1;
          launch <= (scr_mode != vdp_cmd_pix_pkg::SCR_OFF) &&
                    (new_op != vdp_cmd_reg_pkg::OP_STOP);
        end
      end
    end
  end

  // Coordinate and argument registers
  always_ff @(posedge clk21m) begin
    if (wr_pend) begin
      case (reg_num)
        4'd4:  dx[7:0] <= reg_data;
        4'd5:  dx[8]   <= reg_data[0];
        4'd6:  dy[7:0] <= reg_data;
        4'd7:  dy[9:8] <= reg_data[1:0];
        4'd8:  nx[7:0] <= reg_data;
        4'd9:  nx[9:8] <= reg_data[1:0];
        4'd10: ny[7:0] <= reg_data;
        4'd11: ny[9:8] <= reg_data[1:0];
        4'd13: begin
          dix <= reg_data[2];
          diy <= reg_data[3];
        end
        default: ;
      endcase
    end
    // Snapshot for the walker
    if (cmr_wr) begin
      cmd.dx    <= dx;
      cmd.dy    <= dy;
      cmd.nx    <= nx;
      cmd.ny    <= ny;
      cmd.clr   <= clr;
      cmd.dix   <= dix;
      cmd.diy   <= diy;
      cmd.op    <= new_op;
      cmd.logop <= vdp_cmd_reg_pkg::logop_t'(reg_data[3:0]);
    end
  end

  // CPU toggles a new request only once the last one is acknowledged
  a_req_when_idle: assert property (@(posedge clk21m) disable iff (reset)
    $changed(reg_wr_req) |-> $past(reg_wr_req == reg_wr_ack));

  // Walker takes up every launch
  a_launch_busy: assert property (@(posedge clk21m) disable iff (reset)
    launch |=> busy);

endmodule

// File: rtl/vdp_cmd_walker.sv
// Rectangle walker stepping x and y and issuing pixel requests one at a time
`include "vdp_cmd_settings.svh"

module vdp_cmd_walker (
  input  logic                        clk21m,
  input  logic                        reset,
  input  vdp_cmd_reg_pkg::cmd_regs_t  cmd,
  input  logic                        launch,
  input  logic                        abort,
  input  vdp_cmd_pix_pkg::scr_mode_t  scr_mode,
  input  logic                        req_done,
  output vdp_cmd_pix_pkg::pix_req_t   req,
  output logic                        req_valid,
  output logic                        busy,
  output logic                        point_load
);

  // Command being run
  vdp_cmd_reg_pkg::cmd_regs_t run;
  logic [`VDP_CMD_N_W-1:0]    nx_row;

  logic [`VDP_CMD_X_W-1:0] x;
  logic [`VDP_CMD_Y_W-1:0] y;
  logic [`VDP_CMD_N_W-1:0] nx_cnt;
  logic [`VDP_CMD_N_W-1:0] ny_cnt;
  logic [`VDP_CMD_N_W-1:0] nx_init;
  logic [`VDP_CMD_X_W-1:0] x_step;
  logic [`VDP_CMD_X_W-1:0] x_next;
  logic                    byte_g4;
  logic                    single;
  logic                    row_end;
  logic                    last_row;

  // Row length of the new command
  // HMMV in G4 counts bytes
  // A zero count is one pixel
  always_comb begin
    nx_init = cmd.nx;
    if (cmd.op == vdp_cmd_reg_pkg::OP_HMMV && scr_mode == vdp_cmd_pix_pkg::SCR_G4) begin
      nx_init = {1'b0, cmd.nx[`VDP_CMD_N_W-1:1]};
    end
    if (nx_init == '0) begin
      nx_init = `VDP_CMD_N_W'(1);
    end
  end

  assign byte_g4 = (run.op == vdp_cmd_reg_pkg::OP_HMMV) &&
                   (scr_mode == vdp_cmd_pix_pkg::SCR_G4);
  assign single  = (run.op == vdp_cmd_reg_pkg::OP_PSET) ||
                   (run.op == vdp_cmd_reg_pkg::OP_POINT);
  assign x_step  = byte_g4 ? `VDP_CMD_X_W'(2) : `VDP_CMD_X_W'(1);
  assign x_next  = run.dix ? (x - x_step) : (x + x_step);

  // Clip at x >= 256
  // Also catches wrap below 0
  assign row_end  = single || (nx_cnt == `VDP_CMD_N_W'(1)) || x_next[`VDP_CMD_X_W-1];
  assign last_row = single || (ny_cnt == `VDP_CMD_N_W'(1)) || (run.diy && y == '0);

  // Current pixel job
  always_comb begin
    req.x      = x;
    req.y      = y;
    req.colour = run.clr;
    req.logop  = run.logop;
    case (run.op)
      vdp_cmd_reg_pkg::OP_HMMV:  req.kind = vdp_cmd_pix_pkg::KIND_FILL_BYTE;
      vdp_cmd_reg_pkg::OP_POINT: req.kind = vdp_cmd_pix_pkg::KIND_PROBE;
      default:                   req.kind = vdp_cmd_pix_pkg::KIND_MERGE;
    endcase
  end

  always_ff @(posedge clk21m) begin
    if (launch) begin
      run    <= cmd;
      nx_row <= nx_init;
    end
  end

  always_ff @(posedge clk21m or posedge reset) begin
    if (reset) begin
      busy       <= 1'b0;
      req_valid  <= 1'b0;
      point_load <= 1'b0;
      x          <= '0;
      y          <= '0;
      nx_cnt     <= '0;
      ny_cnt     <= '0;
    end else begin
      point_load <= 1'b0;
      // New command wins over the abort that comes with it
      if (launch) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
        x         <= cmd.dx;
        y         <= cmd.dy;
        nx_cnt    <= nx_init;
        ny_cnt    <= (cmd.ny == '0) ? `VDP_CMD_N_W'(1) : cmd.ny;
      end else if (abort) begin
        busy      <= 1'b0;
        req_valid <= 1'b0;
      end else if (busy && req_done) begin
        point_load <= run.op == vdp_cmd_reg_pkg::OP_POINT;
        if (!row_end) begin
          x      <= x_next;
          nx_cnt <= nx_cnt - 1'b1;
        end else if (!last_row) begin
          // Back to DX on the next line
          x      <= run.dx;
          nx_cnt <= nx_row;
          ny_cnt <= ny_cnt - 1'b1;
          y      <= run.diy ? (y - 1'b1) : (y + 1'b1);
        end else begin
          busy      <= 1'b0;
          req_valid <= 1'b0;
        end
      end
    end
  end

  // Port answers only a job that is still offered
  a_done_on_valid: assert property (@(posedge clk21m) disable iff (reset)
    req_done |-> req_valid);

endmodule

// File: rtl/vdp_cmd_vram_port.sv
// VRAM port with address forming, toggle handshakes and logical-op merge
module vdp_cmd_vram_port (
  input  logic                        clk21m,
  input  logic                        reset,
  input  vdp_cmd_pix_pkg::scr_mode_t  scr_mode,
  input  vdp_cmd_pix_pkg::pix_req_t   req,
  input  logic                        req_valid,
  input  logic                        abort,
  input  logic                        vram_rd_ack,
  input  logic                        vram_wr_ack,
  input  logic [7:0]                  vram_rd_data,
  output logic                        req_done,
  output logic [7:0]                  probe_data,
  output logic                        vram_rd_req,
  output logic                        vram_wr_req,
  output vdp_cmd_pix_pkg::vram_addr_t vram_addr,
  output logic [7:0]                  vram_wr_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RD,
    ST_WR
  } state_t;

  state_t                      state;
  vdp_cmd_pix_pkg::pix_req_t   cur;
  vdp_cmd_pix_pkg::vram_addr_t addr;
  vdp_cmd_reg_pkg::logop_t     base_op;
  logic                        aborted;
  logic                        kill;
  logic                        accept;
  logic                        rd_fin;
  logic                        wr_fin;
  logic                        g4;
  logic                        hi_nib;
  logic [7:0]                  rd_pix;
  logic [7:0]                  src;
  logic [7:0]                  res;
  logic [7:0]                  merged;

  assign g4     = scr_mode == vdp_cmd_pix_pkg::SCR_G4;
  // Skip the cycle of our own done, old job still on req
  assign accept = (state == ST_IDLE) && req_valid && !req_done && !abort;
  assign rd_fin = (state == ST_RD) && (vram_rd_req == vram_rd_ack);
  assign wr_fin = (state == ST_WR) && (vram_wr_req == vram_wr_ack);
  assign kill   = aborted | abort;

  // G4 packs two pixels, even x in the high nibble
  assign addr   = g4 ? {req.y[9:0], req.x[7:1]} : {req.y[8:0], req.x[7:0]};
  assign hi_nib = !cur.x[0];
  assign rd_pix = g4 ? {4'h0, hi_nib ? vram_rd_data[7:4] : vram_rd_data[3:0]} : vram_rd_data;
  assign src    = cur.colour & (g4 ? 8'h0F : 8'hFF);

  // Logic op without the transparent bit
  assign base_op = vdp_cmd_reg_pkg::logop_t'({1'b0, cur.logop[2:0]});

  always_comb begin
    // Transparent with colour 0 keeps the old pixel
    if (cur.logop[3] && src == 8'h00) begin
      res = rd_pix;
    end else begin
      case (base_op)
        vdp_cmd_reg_pkg::LOG_IMP: res = src;
        vdp_cmd_reg_pkg::LOG_AND: res = src & rd_pix;
        vdp_cmd_reg_pkg::LOG_OR:  res = src | rd_pix;
        vdp_cmd_reg_pkg::LOG_XOR: res = src ^ rd_pix;
        vdp_cmd_reg_pkg::LOG_NOT: res = ~src;
        default:                  res = rd_pix;
      endcase
    end
  end

  // Reinsert without touching the other nibble
  assign merged = !g4 ? res :
                  hi_nib ? {res[3:0], vram_rd_data[3:0]} : {vram_rd_data[7:4], res[3:0]};

  always_ff @(posedge clk21m or posedge reset) begin
    if (reset) begin
      state       <= ST_IDLE;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
      req_done    <= 1'b0;
      aborted     <= 1'b0;
    end else begin
      req_done <= 1'b0;
      if (abort && state != ST_IDLE) begin
        aborted <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          aborted <= 1'b0;
          if (accept) begin
            if (req.kind == vdp_cmd_pix_pkg::KIND_FILL_BYTE) begin
              vram_wr_req <= ~vram_wr_ack;
              state       <= ST_WR;
            end else begin
              vram_rd_req <= ~vram_rd_ack;
              state       <= ST_RD;
            end
          end
        end
        ST_RD: begin
          if (rd_fin) begin
            // Aborted read ends here, no write-back
            if (kill || cur.kind == vdp_cmd_pix_pkg::KIND_PROBE) begin
              req_done <= !kill;
              state    <= ST_IDLE;
            end else begin
              vram_wr_req <= ~vram_wr_ack;
              state       <= ST_WR;
            end
          end
        end
        ST_WR: begin
          if (wr_fin) begin
            req_done <= !kill;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Job, address and data held through the access
  always_ff @(posedge clk21m) begin
    if (accept) begin
      cur          <= req;
      vram_addr    <= addr;
      vram_wr_data <= req.colour;
    end
    if (rd_fin) begin
      vram_wr_data <= merged;
      if (cur.kind == vdp_cmd_pix_pkg::KIND_PROBE) begin
        probe_data <= rd_pix;
      end
    end
  end

  // New access only once the last one of that type is acknowledged
  a_rd_one_pending: assert property (@(posedge clk21m) disable iff (reset)
    $changed(vram_rd_req) |-> $past(vram_rd_req == vram_rd_ack));
  a_wr_one_pending: assert property (@(posedge clk21m) disable iff (reset)
    $changed(vram_wr_req) |-> $past(vram_wr_req == vram_wr_ack));

endmodule

// File: rtl/vdp_cmd_top.sv
// Drawing-command engine top chaining register file, walker and VRAM port
`include "vdp_cmd_settings.svh"

module vdp_cmd_top (
  input  logic                          clk21m,
  input  logic                          reset,
  input  vdp_cmd_pix_pkg::scr_mode_t    scr_mode,
  // CPU register port
  input  logic                          reg_wr_req,
  input  logic [`VDP_CMD_REGNUM_W-1:0]  reg_num,
  input  logic [7:0]                    reg_data,
  output logic                          reg_wr_ack,
  // VRAM port
  output logic                          vram_rd_req,
  output logic                          vram_wr_req,
  output vdp_cmd_pix_pkg::vram_addr_t   vram_addr,
  output logic [7:0]                    vram_wr_data,
  input  logic                          vram_rd_ack,
  input  logic                          vram_wr_ack,
  input  logic [7:0]                    vram_rd_data,
  // Status
  output logic                          ce,
  output logic [7:0]                    clr
);

  vdp_cmd_reg_pkg::cmd_regs_t cmd;
  vdp_cmd_pix_pkg::pix_req_t  req;
  logic                       launch;
  logic                       abort;
  logic                       busy;
  logic                       point_load;
  logic                       req_valid;
  logic                       req_done;
  logic [7:0]                 probe_data;

  vdp_cmd_regs u_regs (
    .clk21m     (clk21m),
    .reset      (reset),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .scr_mode   (scr_mode),
    .busy       (busy),
    .point_load (point_load),
    .probe_data (probe_data),
    .reg_wr_ack (reg_wr_ack),
    .cmd        (cmd),
    .launch     (launch),
    .abort      (abort),
    .clr        (clr),
    .ce         (ce)
  );

  vdp_cmd_walker u_walker (
    .clk21m     (clk21m),
    .reset      (reset),
    .cmd        (cmd),
    .launch     (launch),
    .abort      (abort),
    .scr_mode   (scr_mode),
    .req_done   (req_done),
    .req        (req),
    .req_valid  (req_valid),
    .busy       (busy),
    .point_load (point_load)
  );

  vdp_cmd_vram_port u_port (
    .clk21m       (clk21m),
    .reset        (reset),
    .scr_mode     (scr_mode),
    .req          (req),
    .req_valid    (req_valid),
    .abort        (abort),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_data (vram_rd_data),
    .req_done     (req_done),
    .probe_data   (probe_data),
    .vram_rd_req  (vram_rd_req),
    .vram_wr_req  (vram_wr_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data)
  );

endmodule

// File: tests/tb_vram_model.sv
// Byte-wide VRAM responder with random acknowledge delay and backdoor array
`include "vdp_cmd_settings.svh"

module tb_vram_model (
  input  logic                        clk21m,
  input  logic                        reset,
  input  logic                        rd_req,
  input  logic                        wr_req,
  input  logic [`VDP_CMD_ADDR_W-1:0]  addr,
  input  logic [7:0]                  wr_data,
  output logic                        rd_ack,
  output logic                        wr_ack,
  output logic [7:0]                  rd_data
);

  // Backdoor, loaded and checked by the testbench
  logic [7:0]  mem [0:(1 << `VDP_CMD_ADDR_W)-1];
  logic [31:0] lfsr;
  logic        rd_busy;
  logic        wr_busy;
  logic [1:0]  rd_wait;
  logic [1:0]  wr_wait;

  initial begin
    lfsr = 32'h1d6905a3;
  end

  // Galois step, taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // Two bits, one step each
  task automatic draw_delay(output logic [1:0] d);
    d[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    d[1] = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  always @(posedge clk21m or posedge reset) begin
    if (reset) begin
      rd_ack  <= 1'b0;
      wr_ack  <= 1'b0;
      rd_data <= 8'h00;
      rd_busy = 1'b0;
      wr_busy = 1'b0;
    end else begin
      // New read seen
      if (!rd_busy && rd_req != rd_ack) begin
        rd_busy = 1'b1;
        draw_delay(rd_wait);
      end
      if (rd_busy) begin
        if (rd_wait == 2'd0) begin
          rd_data <= #1 mem[addr];
          rd_ack  <= #1 rd_req;
          rd_busy = 1'b0;
        end else begin
          rd_wait = rd_wait - 2'd1;
        end
      end
      // New write seen
      if (!wr_busy && wr_req != wr_ack) begin
        wr_busy = 1'b1;
        draw_delay(wr_wait);
      end
      if (wr_busy) begin
        if (wr_wait == 2'd0) begin
          mem[addr] = wr_data;
          wr_ack <= #1 wr_req;
          wr_busy = 1'b0;
        end else begin
          wr_wait = wr_wait - 2'd1;
        end
      end
    end
  end

endmodule

// File: tests/tb_vdp_cmd.sv
// Testbench for the drawing-command engine with test table, reference model and checks
`include "vdp_cmd_settings.svh"

module tb_vdp_cmd;

  localparam int MEM_SIZE = 1 << `VDP_CMD_ADDR_W;

  // One table row
  // arg holds DIX in bit 2 and DIY in bit 3
  // cmr is the raw R46 byte
  typedef struct {
    string                      name;
    vdp_cmd_pix_pkg::scr_mode_t mode;
    logic [8:0]                 dx;
    logic [9:0]                 dy;
    logic [9:0]                 nx;
    logic [9:0]                 ny;
    logic [7:0]                 clr;
    logic [7:0]                 arg;
    logic [7:0]                 cmr;
    logic [7:0]                 pre;
    logic                       mid_stop;
  } test_t;

  localparam int N_TESTS = 12;

  test_t tests [0:N_TESTS-1] = '{
    '{"off_mode",  vdp_cmd_pix_pkg::SCR_OFF, 9'd10, 10'd5, 10'd4, 10'd2, 8'h5A, 8'h00, 8'hC0, 8'h11, 1'b0},
    '{"stop_op",   vdp_cmd_pix_pkg::SCR_G7, 9'd10, 10'd5, 10'd4, 10'd2, 8'h5A, 8'h00, 8'h00, 8'h22, 1'b0},
    '{"hmmv_g7",   vdp_cmd_pix_pkg::SCR_G7, 9'd20, 10'd3, 10'd6, 10'd3, 8'hA5, 8'h00, 8'hC0, 8'h33, 1'b0},
    '{"hmmv_g4",   vdp_cmd_pix_pkg::SCR_G4, 9'd10, 10'd7, 10'd8, 10'd2, 8'h3C, 8'h00, 8'hC0, 8'h44, 1'b0},
    '{"lmmv_xor",  vdp_cmd_pix_pkg::SCR_G4, 9'd9, 10'd2, 10'd5, 10'd3, 8'h07, 8'h04, 8'h83, 8'h55, 1'b0},
    '{"lmmv_clip", vdp_cmd_pix_pkg::SCR_G4, 9'd252, 10'd4, 10'd10, 10'd2, 8'h0E, 8'h00, 8'h80, 8'h66, 1'b0},
    '{"lmmv_diy",  vdp_cmd_pix_pkg::SCR_G7, 9'd30, 10'd1, 10'd3, 10'd4, 8'h81, 8'h08, 8'h82, 8'h77, 1'b0},
    '{"pset_timp", vdp_cmd_pix_pkg::SCR_G7, 9'd40, 10'd9, 10'd0, 10'd0, 8'h00, 8'h00, 8'h58, 8'h88, 1'b0},
    '{"pset_and",  vdp_cmd_pix_pkg::SCR_G4, 9'd41, 10'd9, 10'd0, 10'd0, 8'h0B, 8'h00, 8'h51, 8'h99, 1'b0},
    '{"point_g4",  vdp_cmd_pix_pkg::SCR_G4, 9'd13, 10'd11, 10'd0, 10'd0, 8'h00, 8'h00, 8'h40, 8'hAA, 1'b0},
    '{"point_g7",  vdp_cmd_pix_pkg::SCR_G7, 9'd77, 10'd200, 10'd0, 10'd0, 8'h00, 8'h00, 8'h40, 8'hBB, 1'b0},
    '{"stop_mid",  vdp_cmd_pix_pkg::SCR_G7, 9'd0, 10'd20, 10'd200, 10'd20, 8'h99, 8'h00, 8'hC0, 8'hCC, 1'b1}
  };

  logic                          clk21m;
  logic                          reset;
  vdp_cmd_pix_pkg::scr_mode_t    scr_mode;
  logic                          reg_wr_req;
  logic [`VDP_CMD_REGNUM_W-1:0]  reg_num;
  logic [7:0]                    reg_data;
  logic                          reg_wr_ack;
  logic                          vram_rd_req;
  logic                          vram_wr_req;
  logic [`VDP_CMD_ADDR_W-1:0]    vram_addr;
  logic [7:0]                    vram_wr_data;
  logic                          vram_rd_ack;
  logic                          vram_wr_ack;
  logic [7:0]                    vram_rd_data;
  logic                          ce;
  logic [7:0]                    clr;

  // Reference copy of VRAM
  logic [7:0] exp_mem [0:MEM_SIZE-1];
  logic [7:0] exp_clr;
  int         cycles;
  int         limit;

  vdp_cmd_top u_dut (
    .clk21m       (clk21m),
    .reset        (reset),
    .scr_mode     (scr_mode),
    .reg_wr_req   (reg_wr_req),
    .reg_num      (reg_num),
    .reg_data     (reg_data),
    .reg_wr_ack   (reg_wr_ack),
    .vram_rd_req  (vram_rd_req),
    .vram_wr_req  (vram_wr_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_data (vram_rd_data),
    .ce           (ce),
    .clr          (clr)
  );

  tb_vram_model u_vram (
    .clk21m  (clk21m),
    .reset   (reset),
    .rd_req  (vram_rd_req),
    .wr_req  (vram_wr_req),
    .addr    (vram_addr),
    .wr_data (vram_wr_data),
    .rd_ack  (vram_rd_ack),
    .wr_ack  (vram_wr_ack),
    .rd_data (vram_rd_data)
  );

  initial begin
    clk21m = 1'b0;
    forever #2 clk21m = ~clk21m;
  end

  // Run length guard
  always @(posedge clk21m) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: command did not finish within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error %s: expected %0h, actual %0h", what, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // Preload pattern over every address bit
  function automatic logic [7:0] fill_byte(input logic [16:0] a, input logic [7:0] pre);
    return a[7:0] ^ a[15:8] ^ {a[16], 7'h35} ^ pre;
  endfunction

  function automatic logic [7:0] apply_logop(input logic [7:0] p, input logic [7:0] s,
                                             input logic [3:0] lop);
    // Transparent colour 0 leaves the pixel
    if (lop[3] && s == 8'h00) begin
      return p;
    end
    case (lop[2:0])
      3'd0:    return s;
      3'd1:    return s & p;
      3'd2:    return s | p;
      3'd3:    return s ^ p;
      3'd4:    return ~s;
      default: return p;
    endcase
  endfunction

  // Expected effect of one pixel
  task automatic model_pixel(input test_t t, input logic [8:0] x, input logic [9:0] y);
    logic        g4;
    logic [16:0] a;
    logic [7:0]  b;
    logic [7:0]  p;
    logic [7:0]  s;
    logic [7:0]  r;
    g4 = t.mode == vdp_cmd_pix_pkg::SCR_G4;
    a  = g4 ? {y, x[7:1]} : {y[8:0], x[7:0]};
    b  = exp_mem[a];
    // Even x sits in the high nibble
    p  = g4 ? (x[0] ? {4'h0, b[3:0]} : {4'h0, b[7:4]}) : b;
    s  = g4 ? (t.clr & 8'h0F) : t.clr;
    case (t.cmr[7:4])
      4'hC: exp_mem[a] = t.clr;
      4'h4: exp_clr = p;
      default: begin
        r = apply_logop(p, s, t.cmr[3:0]);
        exp_mem[a] = !g4 ? r : (x[0] ? {b[7:4], r[3:0]} : {r[3:0], b[3:0]});
      end
    endcase
  endtask

  // Walk the rectangle as the command rules describe
  task automatic model_cmd(input test_t t);
    logic [8:0] x;
    logic [8:0] nxt;
    logic [8:0] step;
    logic [9:0] y;
    logic [9:0] rows;
    logic [9:0] cols;
    logic [3:0] op;
    logic       fill_g4;
    op      = t.cmr[7:4];
    exp_clr = t.clr;
    if (t.mode == vdp_cmd_pix_pkg::SCR_OFF || !(op inside {4'h4, 4'h5, 4'h8, 4'hC})) begin
      return;
    end
    if (op == 4'h4 || op == 4'h5) begin
      model_pixel(t, t.dx, t.dy);
      return;
    end
    fill_g4 = op == 4'hC && t.mode == vdp_cmd_pix_pkg::SCR_G4;
    step    = fill_g4 ? 9'd2 : 9'd1;
    cols    = fill_g4 ? (t.nx >> 1) : t.nx;
    if (cols == 0) begin
      cols = 1;
    end
    rows = (t.ny == 0) ? 10'd1 : t.ny;
    y    = t.dy;
    forever begin
      x = t.dx;
      for (int k = 0; k < cols; k++) begin
        model_pixel(t, x, y);
        nxt = t.arg[2] ? (x - step) : (x + step);
        // Right edge or wrap below 0
        if (nxt[8]) begin
          break;
        end
        x = nxt;
      end
      rows = rows - 1;
      if (rows == 0 || (t.arg[3] && y == 0)) begin
        break;
      end
      y = t.arg[3] ? (y - 1) : (y + 1);
    end
  endtask

  // One CPU write through the toggle pair
  task automatic write_reg(input string name, input logic [3:0] num, input logic [7:0] data);
    @(posedge clk21m);
    #1;
    reg_num    = num;
    reg_data   = data;
    reg_wr_req = ~reg_wr_req;
    @(posedge clk21m);
    #1;
    check({name, " ack"}, reg_wr_req, reg_wr_ack);
  endtask

  // STOP during a fill and watch the request lines
  task automatic stop_mid(input string name);
    logic rq;
    logic wq;
    repeat (30) @(posedge clk21m);
    write_reg(name, 4'd14, 8'h00);
    while (vram_rd_req !== vram_rd_ack || vram_wr_req !== vram_wr_ack) begin
      @(negedge clk21m);
    end
    rq = vram_rd_req;
    wq = vram_wr_req;
    repeat (20) begin
      @(negedge clk21m);
      check({name, " rd_req"}, rq, vram_rd_req);
      check({name, " wr_req"}, wq, vram_wr_req);
    end
    check({name, " ce"}, 0, ce);
  endtask

  task automatic run_test(input test_t t);
    logic launches;
    logic [7:0] pre_b;
    for (int a = 0; a < MEM_SIZE; a++) begin
      exp_mem[a]    = fill_byte(17'(a), t.pre);
      u_vram.mem[a] = exp_mem[a];
    end
    @(posedge clk21m);
    #1;
    scr_mode = t.mode;
    model_cmd(t);
    launches = t.mode != vdp_cmd_pix_pkg::SCR_OFF && t.cmr[7:4] inside {4'h4, 4'h5, 4'h8, 4'hC};
    write_reg(t.name, 4'd4, t.dx[7:0]);
    write_reg(t.name, 4'd5, {7'd0, t.dx[8]});
    write_reg(t.name, 4'd6, t.dy[7:0]);
    write_reg(t.name, 4'd7, {6'd0, t.dy[9:8]});
    write_reg(t.name, 4'd8, t.nx[7:0]);
    write_reg(t.name, 4'd9, {6'd0, t.nx[9:8]});
    write_reg(t.name, 4'd10, t.ny[7:0]);
    write_reg(t.name, 4'd11, {6'd0, t.ny[9:8]});
    write_reg(t.name, 4'd12, t.clr);
    write_reg(t.name, 4'd13, t.arg);
    write_reg(t.name, 4'd14, t.cmr);
    // CE one cycle after the R46 acknowledge
    @(posedge clk21m);
    #1;
    check({t.name, " ce"}, launches, ce);
    if (launches) begin
      if (t.mid_stop) begin
        stop_mid(t.name);
      end
      while (ce) begin
        @(negedge clk21m);
      end
    end else begin
      repeat (8) begin
        @(negedge clk21m);
        check({t.name, " ce"}, 0, ce);
      end
    end
    check({t.name, " clr"}, exp_clr, clr);
    for (int a = 0; a < MEM_SIZE; a++) begin
      pre_b = fill_byte(17'(a), t.pre);
      // An aborted fill leaves each byte either old or filled
      if (!(t.mid_stop && u_vram.mem[a] == pre_b)) begin
        check({t.name, " mem"}, exp_mem[a], u_vram.mem[a]);
      end
    end
  endtask

  initial begin
    int cols;
    int rows;
    cycles = 0;
    limit  = 0;
    for (int i = 0; i < N_TESTS; i++) begin
      cols  = (tests[i].nx == 0) ? 1 : tests[i].nx;
      rows  = (tests[i].ny == 0) ? 1 : tests[i].ny;
      limit = limit + cols * rows * 2 * 7 + 200;
    end
    reset      = 1'b1;
    scr_mode   = vdp_cmd_pix_pkg::SCR_OFF;
    reg_wr_req = 1'b0;
    reg_num    = '0;
    reg_data   = 8'h00;
    repeat (5) @(posedge clk21m);
    #1;
    reset = 1'b0;
    check("reset ce", 0, ce);
    check("reset clr", 0, clr);
    check("reset ack", 0, reg_wr_ack);
    check("reset rd_req", vram_rd_ack, vram_rd_req);
    check("reset wr_req", vram_wr_ack, vram_wr_req);
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(tests[i]);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/vdp_cmd_reg_pkg.sv
rtl/vdp_cmd_pix_pkg.sv
rtl/vdp_cmd_regs.sv
rtl/vdp_cmd_walker.sv
rtl/vdp_cmd_vram_port.sv
rtl/vdp_cmd_top.sv
tests/tb_vram_model.sv
tests/tb_vdp_cmd.sv

// File: Bender.yml
package:
  name: vdp_cmd

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vdp_cmd_reg_pkg.sv
      - rtl/vdp_cmd_pix_pkg.sv
      - rtl/vdp_cmd_regs.sv
      - rtl/vdp_cmd_walker.sv
      - rtl/vdp_cmd_vram_port.sv
      - rtl/vdp_cmd_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_vram_model.sv
      - tests/tb_vdp_cmd.sv
